// ==== hdl/histPkg.sv ====
package histPkg;

    // pixels sharing one histogram RAM
    localparam int PIXEL_NUM = 4;
    // time bins per pixel, power of two
    localparam int BIN_NUM = 16;
    // bits per bin counter
    localparam int COUNT_W = 8;

    // derived field widths
    localparam int PIXEL_W = $clog2(PIXEL_NUM);
    localparam int BIN_W = $clog2(BIN_NUM);
    localparam int ADDR_W = PIXEL_W + BIN_W;

    // pixel index of a hit
    typedef logic [PIXEL_W-1:0] pixelT;

    // tdc code, one histogram bin
    typedef logic [BIN_W-1:0] binT;

    // ram word address, pixel * BIN_NUM + bin
    typedef logic [ADDR_W-1:0] ramAddrT;

    // photon count held in one bin
    typedef logic [COUNT_W-1:0] countT;

endpackage

// ==== hdl/histRamIf.sv ====
interface histRamIf;
    import histPkg::*;

    // write port, owned by the builder
    logic wEn;
    ramAddrT wAddr;
    countT wData;

    // update read port for read-modify-write
    logic rEn;
    ramAddrT rAddr;
    countT rData;

    // scan read port for the peak search
    logic sEn;
    ramAddrT sAddr;
    countT sData;

    // histogram builder side
    modport builder (
        output wEn, wAddr, wData, rEn, rAddr,
        input rData
    );

    // memory side, both read ports are registered
    modport ram (
        input wEn, wAddr, wData, rEn, rAddr, sEn, sAddr,
        output rData, sData
    );

    // peak finder side
    modport scanner (
        output sEn, sAddr,
        input sData
    );

endinterface

// ==== hdl/histBuilder.sv ====
module histBuilder #(
    parameter int PIXEL_NUM = histPkg::PIXEL_NUM,
    parameter int BIN_NUM = histPkg::BIN_NUM
) (
    input logic clk,
    input logic res,
    input logic hitStrobe,
    input histPkg::pixelT hitPixel,
    input histPkg::binT hitBin,
    input logic clearStart,
    input logic scanBusy,
    output logic clearBusy,
    histRamIf.builder ram
);
    import histPkg::*;

    // IDLE until the first clear, since ram contents are undefined
    typedef enum logic [1:0] {
        IDLE,
        CLEAR,
        RUN
    } stateT;

    localparam ramAddrT LAST_ADDR = ramAddrT'(PIXEL_NUM * BIN_NUM - 1);

    stateT state;

    logic clearAccept;
    logic hitAccept;
    ramAddrT hitAddr;

    // stage 1, read issued, data due next cycle
    logic s1Valid;
    ramAddrT s1Addr;

    // write that committed on the last edge
    logic prevEn;
    ramAddrT prevAddr;
    countT prevData;

    // forwarded count and its saturated increment
    countT baseCount;
    countT nextCount;

    // commands are dropped while a readout or a clear is running
    assign clearAccept = clearStart && (state != CLEAR) && !scanBusy;

    // clear wins over a hit in the same cycle
    assign hitAccept = hitStrobe && (state == RUN) && !scanBusy && !clearStart;

    assign hitAddr = ramAddrT'(hitPixel) * ramAddrT'(BIN_NUM) + ramAddrT'(hitBin);

    // stage 1 read goes out combinationally in the hit cycle
    assign ram.rEn = hitAccept;
    assign ram.rAddr = hitAddr;

    assign clearBusy = (state == CLEAR);

    always_comb begin
        // newest pending write first, it already holds older updates
        if (ram.wEn && (ram.wAddr == s1Addr)) begin
            baseCount = ram.wData;
        end else if (prevEn && (prevAddr == s1Addr)) begin
            // written on the same edge as our read, ram gave old data
            baseCount = prevData;
        end else begin
            baseCount = ram.rData;
        end
        // hold at all ones
        if (baseCount == '1) begin
            nextCount = baseCount;
        end else begin
            nextCount = baseCount + 1'b1;
        end
    end

    // control state
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= IDLE;
            s1Valid <= 1'b0;
            prevEn <= 1'b0;
            ram.wEn <= 1'b0;
        end else begin
            prevEn <= ram.wEn;
            s1Valid <= hitAccept;
            if (clearAccept) begin
                // in-flight hit is dropped, its bin is about to be zeroed
                state <= CLEAR;
                ram.wEn <= 1'b1;
            end else if (state == CLEAR) begin
                // one zero write per cycle
                if (ram.wAddr == LAST_ADDR) begin
                    state <= RUN;
                    ram.wEn <= 1'b0;
                end
            end else begin
                // stage 3 write, two cycles after the hit
                ram.wEn <= s1Valid;
            end
        end
    end

    // addresses and data
    always_ff @(posedge clk) begin
        s1Addr <= hitAddr;
        prevAddr <= ram.wAddr;
        prevData <= ram.wData;
        if (clearAccept) begin
            ram.wAddr <= '0;
            ram.wData <= '0;
        end else if (state == CLEAR) begin
            // sweep address, data stays zero
            ram.wAddr <= ram.wAddr + 1'b1;
        end else begin
            ram.wAddr <= s1Addr;
            ram.wData <= nextCount;
        end
    end

endmodule

// ==== hdl/histRam.sv ====
module histRam #(
    parameter int PIXEL_NUM = histPkg::PIXEL_NUM,
    parameter int BIN_NUM = histPkg::BIN_NUM
) (
    input logic clk,
    histRamIf.ram mem
);
    import histPkg::*;

    localparam int DEPTH = PIXEL_NUM * BIN_NUM;

    // one word per pixel and bin
    countT store [DEPTH];

    // single write port
    always_ff @(posedge clk) begin
        if (mem.wEn) begin
            store[mem.wAddr] <= mem.wData;
        end
    end

    // update read port
    // same-address write in this cycle is not seen yet
    always_ff @(posedge clk) begin
        if (mem.rEn) begin
            mem.rData <= store[mem.rAddr];
        end
    end

    // scan read port, independent of the update path
    always_ff @(posedge clk) begin
        if (mem.sEn) begin
            mem.sData <= store[mem.sAddr];
        end
    end

endmodule

// ==== hdl/peakFinder.sv ====
module peakFinder #(
    parameter int PIXEL_NUM = histPkg::PIXEL_NUM,
    parameter int BIN_NUM = histPkg::BIN_NUM
) (
    input logic clk,
    input logic res,
    input logic readoutStart,
    input logic clearBusy,
    output logic scanBusy,
    output logic peakValid,
    output histPkg::pixelT peakPixel,
    output histPkg::binT peakBin,
    output histPkg::countT peakCount,
    output logic readoutDone,
    histRamIf.scanner ram
);
    import histPkg::*;

    typedef enum logic [1:0] {
        IDLE,
        SCAN,
        LAST,
        DONE
    } stateT;

    localparam ramAddrT LAST_ADDR = ramAddrT'(PIXEL_NUM * BIN_NUM - 1);
    localparam binT LAST_BIN = binT'(BIN_NUM - 1);

    stateT state;
    logic startAccept;

    // address of the word now on sData
    logic dValid;
    ramAddrT dAddr;
    pixelT dPixel;
    binT dBin;

    // running maximum of the current pixel
    countT runMax;
    binT runBin;

    // maximum including the word now returning
    countT candCount;
    binT candBin;

    assign startAccept = readoutStart && !clearBusy && !scanBusy;

    // held through the done pulse
    assign scanBusy = (state != IDLE) || readoutDone;

    assign dPixel = pixelT'(dAddr / ramAddrT'(BIN_NUM));
    assign dBin = binT'(dAddr % ramAddrT'(BIN_NUM));

    always_comb begin
        // first bin restarts the search, strict compare keeps lowest bin on ties
        if ((dBin == '0) || (ram.sData > runMax)) begin
            candCount = ram.sData;
            candBin = dBin;
        end else begin
            candCount = runMax;
            candBin = runBin;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= IDLE;
            ram.sEn <= 1'b0;
            dValid <= 1'b0;
            peakValid <= 1'b0;
            readoutDone <= 1'b0;
        end else begin
            dValid <= ram.sEn;
            // one strobe when a pixel's last bin returns
            peakValid <= dValid && (dBin == LAST_BIN);
            readoutDone <= 1'b0;
            case (state)
                IDLE: begin
                    if (startAccept) begin
                        state <= SCAN;
                        ram.sEn <= 1'b1;
                    end
                end
                SCAN: begin
                    // one read per cycle over all pixels
                    if (ram.sAddr == LAST_ADDR) begin
                        state <= LAST;
                        ram.sEn <= 1'b0;
                    end
                end
                LAST: begin
                    // final word is on sData, last peak goes out
                    state <= DONE;
                end
                DONE: begin
                    readoutDone <= 1'b1;
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        dAddr <= ram.sAddr;
        if (startAccept) begin
            ram.sAddr <= '0;
        end else if (ram.sEn) begin
            ram.sAddr <= ram.sAddr + 1'b1;
        end
        if (dValid) begin
            runMax <= candCount;
            runBin <= candBin;
        end
        // peak of the finished pixel
        if (dValid && (dBin == LAST_BIN)) begin
            peakPixel <= dPixel;
            peakBin <= candBin;
            peakCount <= candCount;
        end
    end

endmodule

// ==== hdl/histTop.sv ====
module histTop #(
    parameter int PIXEL_NUM = histPkg::PIXEL_NUM,
    parameter int BIN_NUM = histPkg::BIN_NUM
) (
    input logic clk,
    input logic res,
    input logic hitStrobe,
    input histPkg::pixelT hitPixel,
    input histPkg::binT hitBin,
    input logic clearStart,
    input logic readoutStart,
    output logic busy,
    output logic peakValid,
    output histPkg::pixelT peakPixel,
    output histPkg::binT peakBin,
    output histPkg::countT peakCount,
    output logic readoutDone
);

    logic clearBusy;
    logic scanBusy;

    // all three ram ports
    histRamIf ramBus ();

    // clear sweep and hit updates
    histBuilder #(
        .PIXEL_NUM(PIXEL_NUM),
        .BIN_NUM(BIN_NUM)
    ) builder (
        .clk(clk),
        .res(res),
        .hitStrobe(hitStrobe),
        .hitPixel(hitPixel),
        .hitBin(hitBin),
        .clearStart(clearStart),
        .scanBusy(scanBusy),
        .clearBusy(clearBusy),
        .ram(ramBus.builder)
    );

    histRam #(
        .PIXEL_NUM(PIXEL_NUM),
        .BIN_NUM(BIN_NUM)
    ) mem (
        .clk(clk),
        .mem(ramBus.ram)
    );

    // readout scan and peak search
    peakFinder #(
        .PIXEL_NUM(PIXEL_NUM),
        .BIN_NUM(BIN_NUM)
    ) finder (
        .clk(clk),
        .res(res),
        .readoutStart(readoutStart),
        .clearBusy(clearBusy),
        .scanBusy(scanBusy),
        .peakValid(peakValid),
        .peakPixel(peakPixel),
        .peakBin(peakBin),
        .peakCount(peakCount),
        .readoutDone(readoutDone),
        .ram(ramBus.scanner)
    );

    // hits and commands are dropped while either side is busy
    assign busy = clearBusy || scanBusy;

endmodule

// ==== verification/histTb.sv ====
module histTb;
    timeunit 1ns;
    timeprecision 100ps;

    import histPkg::*;

    localparam int MAX_COUNT = (1 << COUNT_W) - 1;
    localparam int CLEAR_CYCLES = PIXEL_NUM * BIN_NUM;

    // rough run length in cycles
    localparam int HIT_CYCLES = 1000;
    localparam int READ_CYCLES = 70;
    localparam int NUM_CLEARS = 2;
    localparam int NUM_READS = 7;
    // twice the estimate as margin
    localparam int CYCLE_LIMIT =
        2 * (HIT_CYCLES + NUM_CLEARS * CLEAR_CYCLES + NUM_READS * READ_CYCLES);

    logic clk;
    logic res;
    logic hitStrobe;
    pixelT hitPixel;
    binT hitBin;
    logic clearStart;
    logic readoutStart;
    logic busy;
    logic peakValid;
    pixelT peakPixel;
    binT peakBin;
    countT peakCount;
    logic readoutDone;

    // reference histogram, one counter per pixel and bin
    int model [PIXEL_NUM][BIN_NUM];
    // peaks reported by the last readout
    int gotBin [PIXEL_NUM];
    int gotCount [PIXEL_NUM];

    int errors;
    int seed;
    int cycleCount;

    histTop #(
        .PIXEL_NUM(PIXEL_NUM),
        .BIN_NUM(BIN_NUM)
    ) DUT (
        .clk(clk),
        .res(res),
        .hitStrobe(hitStrobe),
        .hitPixel(hitPixel),
        .hitBin(hitBin),
        .clearStart(clearStart),
        .readoutStart(readoutStart),
        .busy(busy),
        .peakValid(peakValid),
        .peakPixel(peakPixel),
        .peakBin(peakBin),
        .peakCount(peakCount),
        .readoutDone(readoutDone)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // uniform value in 0..n-1
    function automatic int randBelow(input int n);
        randBelow = ($random(seed) & 32'h7fffffff) % n;
    endfunction

    // lowest bin wins on equal counts
    function automatic void expectedPeak(input int p, output int b, output int c);
        b = 0;
        c = model[p][0];
        for (int i = 1; i < BIN_NUM; i++) begin
            if (model[p][i] > c) begin
                c = model[p][i];
                b = i;
            end
        end
    endfunction

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(negedge clk);
            hitStrobe = 1'b0;
            clearStart = 1'b0;
            readoutStart = 1'b0;
        end
    endtask

    task automatic sendHit(input int p, input int b);
        @(negedge clk);
        hitStrobe = 1'b1;
        hitPixel = pixelT'(p);
        hitBin = binT'(b);
        clearStart = 1'b0;
        readoutStart = 1'b0;
        // busy seen here holds until the sampling edge
        if (!busy && model[p][b] < MAX_COUNT) begin
            model[p][b]++;
        end
    endtask

    task automatic waitIdle(input string name);
        int waitCnt;
        waitCnt = 0;
        while (busy && waitCnt < 4 * READ_CYCLES) begin
            @(negedge clk);
            waitCnt++;
        end
        if (busy) begin
            errors++;
            $display("%s: busy did not fall before the next command", name);
        end
    endtask

    // clear sweep, optionally with hits and readout requests thrown in while busy
    task automatic runClear(input string name, input bit inject);
        int busyCycles;
        bit stray;
        waitIdle(name);
        idleCycles(3);
        @(negedge clk);
        clearStart = 1'b1;
        @(negedge clk);
        clearStart = 1'b0;
        busyCycles = 0;
        stray = 1'b0;
        while (busy && busyCycles < 4 * CLEAR_CYCLES) begin
            busyCycles++;
            if (peakValid || readoutDone) begin
                stray = 1'b1;
            end
            if (inject) begin
                hitStrobe = 1'b1;
                readoutStart = 1'b1;
                hitPixel = pixelT'(randBelow(PIXEL_NUM));
                hitBin = binT'(randBelow(BIN_NUM));
            end
            @(negedge clk);
        end
        hitStrobe = 1'b0;
        readoutStart = 1'b0;
        if (busyCycles != CLEAR_CYCLES) begin
            errors++;
            $display("error %s: busy cycles expected %0d actual %0d",
                name, CLEAR_CYCLES, busyCycles);
        end
        foreach (model[p, b]) begin
            model[p][b] = 0;
        end
        // a dropped readout request must not start late
        repeat (5) begin
            @(negedge clk);
            if (busy || peakValid || readoutDone) begin
                stray = 1'b1;
            end
        end
        if (stray) begin
            errors++;
            $display("%s: readout activity seen during or after the clear", name);
        end
    endtask

    // full readout, peaks compared in pixel order against the model
    task automatic runReadout(input string name, input bit inject);
        int expBin [PIXEL_NUM];
        int expCount [PIXEL_NUM];
        int nPeaks;
        int waitCnt;
        bit done;
        waitIdle(name);
        idleCycles(3);
        for (int p = 0; p < PIXEL_NUM; p++) begin
            expectedPeak(p, expBin[p], expCount[p]);
        end
        @(negedge clk);
        readoutStart = 1'b1;
        nPeaks = 0;
        waitCnt = 0;
        done = 1'b0;
        while (!done && waitCnt < 4 * READ_CYCLES) begin
            @(negedge clk);
            readoutStart = 1'b0;
            hitStrobe = 1'b0;
            waitCnt++;
            if (peakValid) begin
                if (nPeaks < PIXEL_NUM) begin
                    if (int'(peakPixel) != nPeaks) begin
                        errors++;
                        $display("error %s: peakPixel expected %0d actual %0d",
                            name, nPeaks, peakPixel);
                    end
                    if (int'(peakBin) != expBin[nPeaks]) begin
                        errors++;
                        $display("error %s: pixel %0d peakBin expected %0d actual %0d",
                            name, nPeaks, expBin[nPeaks], peakBin);
                    end
                    if (int'(peakCount) != expCount[nPeaks]) begin
                        errors++;
                        $display("error %s: pixel %0d peakCount expected %0d actual %0d",
                            name, nPeaks, expCount[nPeaks], peakCount);
                    end
                    gotBin[nPeaks] = int'(peakBin);
                    gotCount[nPeaks] = int'(peakCount);
                end
                nPeaks++;
            end
            if (readoutDone) begin
                done = 1'b1;
            end else if (inject && busy) begin
                // all of these must be dropped by the DUT
                hitStrobe = 1'b1;
                readoutStart = 1'b1;
                hitPixel = pixelT'(randBelow(PIXEL_NUM));
                hitBin = binT'(randBelow(BIN_NUM));
            end
        end
        if (!done) begin
            errors++;
            $display("%s: readoutDone never came", name);
        end
        if (nPeaks != PIXEL_NUM) begin
            errors++;
            $display("error %s: peak strobes expected %0d actual %0d", name, PIXEL_NUM, nPeaks);
        end
        @(negedge clk);
        if (busy) begin
            errors++;
            $display("%s: busy still high one cycle after readoutDone", name);
        end
    endtask

    initial begin
        int sent;
        int pa;
        int ba;
        int pb;
        int bb;
        int satPixel;
        int satBin;
        errors = 0;
        seed = 32'h57ff79e1;
        res = 1'b0;
        hitStrobe = 1'b0;
        hitPixel = '0;
        hitBin = '0;
        clearStart = 1'b0;
        readoutStart = 1'b0;
        foreach (model[p, b]) begin
            model[p][b] = 0;
        end
        repeat (4) @(negedge clk);
        res = 1'b1;
        if (busy || peakValid || readoutDone) begin
            errors++;
            $display("reset: busy or a result strobe is high after reset");
        end

        // fresh clear, every peak must be zero
        runClear("clear", 1'b0);
        runReadout("clear", 1'b0);

        // sparse random hits
        sent = 0;
        while (sent < 200) begin
            if (randBelow(2) == 1) begin
                sendHit(randBelow(PIXEL_NUM), randBelow(BIN_NUM));
                sent++;
            end else begin
                idleCycles(1);
            end
        end
        idleCycles(3);
        runReadout("random", 1'b0);

        // same address back to back, alternating, and with one gap
        for (int k = 0; k < 4; k++) begin
            pa = randBelow(PIXEL_NUM);
            ba = randBelow(BIN_NUM);
            pb = randBelow(PIXEL_NUM);
            bb = randBelow(BIN_NUM);
            repeat (8) sendHit(pa, ba);
            for (int i = 0; i < 12; i++) begin
                if (i % 2 == 0) begin
                    sendHit(pa, ba);
                end else begin
                    sendHit(pb, bb);
                end
            end
            repeat (4) begin
                sendHit(pa, ba);
                idleCycles(1);
            end
            idleCycles(3);
        end
        runReadout("forward", 1'b0);

        // one bin pushed past full scale
        satPixel = randBelow(PIXEL_NUM);
        satBin = randBelow(BIN_NUM);
        repeat (300) sendHit(satPixel, satBin);
        idleCycles(3);
        runReadout("saturate", 1'b0);
        if (gotCount[satPixel] != MAX_COUNT) begin
            errors++;
            $display("error saturate: count expected %0d actual %0d",
                MAX_COUNT, gotCount[satPixel]);
        end
        if (gotBin[satPixel] != satBin) begin
            errors++;
            $display("error saturate: bin expected %0d actual %0d", satBin, gotBin[satPixel]);
        end

        // traffic while busy, second readout shows nothing landed
        runReadout("dropped", 1'b1);
        runReadout("dropped", 1'b0);
        runClear("dropped", 1'b1);
        runReadout("dropped", 1'b0);

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // hard stop if something hangs
    initial begin
        cycleCount = 0;
        while (cycleCount < CYCLE_LIMIT) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: run did not end within %0d cycles", CYCLE_LIMIT);
        $display("Some tests failed");
        $finish;
    end

endmodule

// ==== all.f ====
hdl/histPkg.sv
hdl/histRamIf.sv
hdl/histBuilder.sv
hdl/histRam.sv
hdl/peakFinder.sv
hdl/histTop.sv
verification/histTb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the histogram testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
    -f all.f --top-module histTb -Mdir "$BUILD_DIR" -o histSim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

"./$BUILD_DIR/histSim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the log decides pass or fail
grep -q "All tests passed" "$LOG"
if [ $? -ne 0 ]; then
    echo "simulation failed, see $LOG"
    exit 1
fi

echo "simulation passed"
exit 0
